// ==== rtl/ctrl_monitor_pkg.sv ====
`default_nettype none

package ctrl_monitor_pkg;

  //////////////////////////////////////////////////////////////////////
  // Controller encodings
  //////////////////////////////////////////////////////////////////////

  // PC source that the controller selects when it redirects fetch
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_MRET     = 3'd2,
    PC_BRANCH   = 3'd3,
    PC_TRAP_NMI = 3'd4,
    PC_TRAP_EXC = 3'd5,
    PC_DRET     = 3'd6
  } pc_mux_e;

  //////////////////////////////////////////////////////////////////////
  // Violation codes and check vectors
  //////////////////////////////////////////////////////////////////////

  // The code value is also the bit position in the check vector
  typedef enum logic [2:0] {
    CHK_B2B_BRANCH         = 3'd0,
    CHK_B2B_JUMP           = 3'd1,
    CHK_FENCEI_NO_WB       = 3'd2,
    CHK_FENCEI_EARLY_CLEAR = 3'd3,
    CHK_FENCEI_STUCK       = 3'd4,
    CHK_FENCEI_NOT_READY   = 3'd5,
    CHK_BUS_ERR_TYPE       = 3'd6,
    CHK_NMI_RETIRE         = 3'd7
  } check_e;

  localparam int unsigned N_CHECKS = 8;

  typedef logic [N_CHECKS-1:0] chk_vec_t;

  // Flow checks own codes 0 to 5, the bus tracker codes 6 and 7
  typedef logic [5:0] flow_flags_t;
  typedef logic [1:0] bus_flags_t;

  localparam int unsigned STAMP_W_DEFAULT = 16;

endpackage

`default_nettype wire

// ==== rtl/ctrl_event_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Registered controller and data-bus events, all from the same input cycle
interface ctrl_event_if #(
  parameter int unsigned STAMP_W = 16
);

  logic                      pc_set;
  ctrl_monitor_pkg::pc_mux_e pc_mux;
  logic                      obi_req;
  logic                      obi_gnt;
  logic                      obi_we;
  logic                      obi_rvalid;
  logic                      obi_err;
  logic                      wb_valid;
  logic                      last_op_wb;
  logic                      fencei_in_wb;
  logic                      fencei_flush_req;
  logic                      fencei_flush_ack;
  logic                      fencei_ready;
  logic                      nmi_pending;
  logic                      nmi_is_store;
  // Cycle stamp that belongs to the events above
  logic [STAMP_W-1:0]        stamp;

  modport sampler (
    output pc_set, pc_mux, obi_req, obi_gnt, obi_we, obi_rvalid, obi_err,
           wb_valid, last_op_wb, fencei_in_wb, fencei_flush_req,
           fencei_flush_ack, fencei_ready, nmi_pending, nmi_is_store, stamp
  );

  modport check (
    input pc_set, pc_mux, obi_req, obi_gnt, obi_we, obi_rvalid, obi_err,
          wb_valid, last_op_wb, fencei_in_wb, fencei_flush_req,
          fencei_flush_ack, fencei_ready, nmi_pending, nmi_is_store, stamp
  );

endinterface

`default_nettype wire

// ==== rtl/ctrl_event_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_event_sampler #(
  parameter int unsigned STAMP_W = 16
) (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            pc_set_i,
  input  wire ctrl_monitor_pkg::pc_mux_e pc_mux_i,
  input  wire                            obi_req_i,
  input  wire                            obi_gnt_i,
  input  wire                            obi_we_i,
  input  wire                            obi_rvalid_i,
  input  wire                            obi_err_i,
  input  wire                            wb_valid_i,
  input  wire                            last_op_wb_i,
  input  wire                            fencei_in_wb_i,
  input  wire                            fencei_flush_req_i,
  input  wire                            fencei_flush_ack_i,
  input  wire                            fencei_ready_i,
  input  wire                            nmi_pending_i,
  input  wire                            nmi_is_store_i,
  ctrl_event_if.sampler                  ev
);

  logic [STAMP_W-1:0] stamp_q;

  // Free-running cycle stamp, it wraps at its width
  // After edge N it holds N, which is the stamp of the events taken at edge N
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stamp_q <= '0;
    end else begin
      stamp_q <= stamp_q + 1'b1;
    end
  end

  assign ev.stamp = stamp_q;

  // One register stage for every monitored input
  // Clearing them keeps the checkers quiet in the first cycle after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ev.pc_set           <= 1'b0;
      ev.pc_mux           <= ctrl_monitor_pkg::PC_BOOT;
      ev.obi_req          <= 1'b0;
      ev.obi_gnt          <= 1'b0;
      ev.obi_we           <= 1'b0;
      ev.obi_rvalid       <= 1'b0;
      ev.obi_err          <= 1'b0;
      ev.wb_valid         <= 1'b0;
      ev.last_op_wb       <= 1'b0;
      ev.fencei_in_wb     <= 1'b0;
      ev.fencei_flush_req <= 1'b0;
      ev.fencei_flush_ack <= 1'b0;
      ev.fencei_ready     <= 1'b0;
      ev.nmi_pending      <= 1'b0;
      ev.nmi_is_store     <= 1'b0;
    end else begin
      ev.pc_set           <= pc_set_i;
      ev.pc_mux           <= pc_mux_i;
      ev.obi_req          <= obi_req_i;
      ev.obi_gnt          <= obi_gnt_i;
      ev.obi_we           <= obi_we_i;
      ev.obi_rvalid       <= obi_rvalid_i;
      ev.obi_err          <= obi_err_i;
      ev.wb_valid         <= wb_valid_i;
      ev.last_op_wb       <= last_op_wb_i;
      ev.fencei_in_wb     <= fencei_in_wb_i;
      ev.fencei_flush_req <= fencei_flush_req_i;
      ev.fencei_flush_ack <= fencei_flush_ack_i;
      ev.fencei_ready     <= fencei_ready_i;
      ev.nmi_pending      <= nmi_pending_i;
      ev.nmi_is_store     <= nmi_is_store_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bus_error_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_error_tracker (
  input  wire                          clk,
  input  wire                          rst_n,
  ctrl_event_if.check                  ev,
  output ctrl_monitor_pkg::bus_flags_t flags_o
);

  logic       accepted;
  logic       oldest_we;
  logic       err_event;
  logic       nmi_taken;
  logic       retire;
  logic [1:0] retire_limit;
  logic [1:0] out_cnt_q;
  // Write enables of outstanding transactions, bit 1 is the older one
  logic [1:0] out_we_q;
  logic       err_latched_q;
  logic       err_is_write_q;
  logic       retire_at_err_q;
  logic       type_armed_q;
  logic [1:0] retire_cnt_q;

  assign accepted  = ev.obi_req && ev.obi_gnt;
  assign oldest_we = (out_cnt_q == 2'd2) ? out_we_q[1] : out_we_q[0];
  // Only the first error response counts until the NMI is taken
  assign err_event = ev.obi_rvalid && ev.obi_err && !err_latched_q;
  assign nmi_taken = ev.pc_set && (ev.pc_mux == ctrl_monitor_pkg::PC_TRAP_NMI);
  assign retire    = ev.wb_valid && ev.last_op_wb;

  //////////////////////////////////////////////////////////////////////
  // Outstanding transaction queue
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q <= 2'd0;
      out_we_q  <= 2'b00;
    end else begin
      if (accepted && !ev.obi_rvalid) begin
        // New entry goes in at bit 0, the older one moves up
        out_cnt_q <= out_cnt_q + 2'd1;
        out_we_q  <= {out_we_q[0], ev.obi_we};
      end else if (!accepted && ev.obi_rvalid) begin
        // The oldest retires, so bit 0 becomes the oldest when one is left
        out_cnt_q <= out_cnt_q - 2'd1;
      end else if (accepted && ev.obi_rvalid) begin
        // Count stays, the oldest leaves and the new one enters
        if (out_cnt_q == 2'd2) begin
          out_we_q <= {out_we_q[0], ev.obi_we};
        end else begin
          out_we_q[0] <= ev.obi_we;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Error latch and retire counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_latched_q   <= 1'b0;
      err_is_write_q  <= 1'b0;
      retire_at_err_q <= 1'b0;
      type_armed_q    <= 1'b0;
    end else begin
      // The type check runs exactly once, one cycle after the latch
      type_armed_q <= err_event;
      if (err_event) begin
        err_latched_q   <= 1'b1;
        err_is_write_q  <= oldest_we;
        retire_at_err_q <= ev.wb_valid;
      end else if (nmi_taken) begin
        err_latched_q <= 1'b0;
      end
    end
  end

  // One retirement fewer is allowed if one coincided with the error
  assign retire_limit = retire_at_err_q ? 2'd2 : 2'd3;

  // Counter saturates at the limit so the violation is reported once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_cnt_q <= 2'd0;
    end else if (!err_latched_q) begin
      retire_cnt_q <= 2'd0;
    end else if (retire && (retire_cnt_q != retire_limit)) begin
      retire_cnt_q <= retire_cnt_q + 2'd1;
    end
  end

  // Bit 0 is CHK_BUS_ERR_TYPE and bit 1 is CHK_NMI_RETIRE
  assign flags_o[0] = type_armed_q &&
                      (!ev.nmi_pending || (ev.nmi_is_store != err_is_write_q));
  assign flags_o[1] = err_latched_q && retire && (retire_cnt_q == retire_limit - 2'd1);

  // A third transaction is never granted while two are still waiting for rvalid
  a_outstanding_max :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (accepted && (out_cnt_q == 2'd2)) |-> ev.obi_rvalid)
      else $error("More than two outstanding data-bus transactions");

endmodule

`default_nettype wire

// ==== rtl/ctrl_flow_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_flow_checker (
  input  wire                           clk,
  input  wire                           rst_n,
  ctrl_event_if.check                   ev,
  output ctrl_monitor_pkg::flow_flags_t flags_o
);

  logic branch_taken;
  logic jump_taken;
  logic req_and_ack;
  logic branch_q;
  logic jump_q;
  logic req_q;
  logic req_and_ack_q;

  //////////////////////////////////////////////////////////////////////
  // Current cycle events
  //////////////////////////////////////////////////////////////////////

  assign branch_taken = ev.pc_set && (ev.pc_mux == ctrl_monitor_pkg::PC_BRANCH);

  // An mret redirect behaves like a jump for the IF kill rule
  assign jump_taken = ev.pc_set && ((ev.pc_mux == ctrl_monitor_pkg::PC_JUMP) ||
                                    (ev.pc_mux == ctrl_monitor_pkg::PC_MRET));

  assign req_and_ack = ev.fencei_flush_req && ev.fencei_flush_ack;

  // Previous cycle history
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      branch_q      <= 1'b0;
      jump_q        <= 1'b0;
      req_q         <= 1'b0;
      req_and_ack_q <= 1'b0;
    end else begin
      branch_q      <= branch_taken;
      jump_q        <= jump_taken;
      req_q         <= ev.fencei_flush_req;
      req_and_ack_q <= req_and_ack;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Flags, indexed by check code
  //////////////////////////////////////////////////////////////////////

  // IF and ID are killed after a redirect, so two in a row is illegal
  assign flags_o[ctrl_monitor_pkg::CHK_B2B_BRANCH] = branch_taken && branch_q;
  assign flags_o[ctrl_monitor_pkg::CHK_B2B_JUMP]   = jump_taken && jump_q;

  // The flush handshake only runs with a fence.i in writeback
  assign flags_o[ctrl_monitor_pkg::CHK_FENCEI_NO_WB] =
    ev.fencei_flush_req && !ev.fencei_in_wb;

  // A request that was high last cycle without ack must still be high
  assign flags_o[ctrl_monitor_pkg::CHK_FENCEI_EARLY_CLEAR] =
    req_q && !req_and_ack_q && !ev.fencei_flush_req;

  // After req and ack the request drops in the very next cycle
  assign flags_o[ctrl_monitor_pkg::CHK_FENCEI_STUCK] =
    req_and_ack_q && ev.fencei_flush_req;

  // Write buffer must be empty while the handshake is active
  assign flags_o[ctrl_monitor_pkg::CHK_FENCEI_NOT_READY] =
    ev.fencei_flush_req && !ev.fencei_ready;

endmodule

`default_nettype wire

// ==== rtl/viol_reporter.sv ====
`timescale 1ns/1ps
`default_nettype none

module viol_reporter #(
  parameter int unsigned DEPTH   = 4,
  parameter int unsigned CREDITS = 2,
  parameter int unsigned STAMP_W = 16
) (
  input  wire                             clk,
  input  wire                             rst_n,
  ctrl_event_if.check                     ev,
  input  wire ctrl_monitor_pkg::chk_vec_t flags_i,
  input  wire                             credit_i,
  output logic                            viol_valid_o,
  output ctrl_monitor_pkg::check_e        viol_code_o,
  output logic [STAMP_W-1:0]              viol_stamp_o,
  output logic                            overflow_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam int unsigned CRD_W = $clog2(CREDITS + 1);

  ctrl_monitor_pkg::chk_vec_t vec_mem [DEPTH];
  logic [STAMP_W-1:0]         stamp_mem [DEPTH];
  logic [PTR_W-1:0]           wr_ptr_q;
  logic [PTR_W-1:0]           rd_ptr_q;
  logic [CNT_W-1:0]           count_q;
  logic [CRD_W-1:0]           credit_q;
  // Bits of the head vector that have already left as records
  ctrl_monitor_pkg::chk_vec_t sent_q;
  ctrl_monitor_pkg::chk_vec_t pending;
  ctrl_monitor_pkg::chk_vec_t pick;
  logic                       empty;
  logic                       full;
  logic                       push;
  logic                       pop;

  assign empty = (count_q == '0);
  assign full  = (count_q == CNT_W'(DEPTH));
  // A vector that finds the queue full is lost
  assign push  = (flags_i != '0) && !full;

  //////////////////////////////////////////////////////////////////////
  // Vector FIFO
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      vec_mem[wr_ptr_q]   <= flags_i;
      stamp_mem[wr_ptr_q] <= ev.stamp;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push && pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Serializer and credits
  //////////////////////////////////////////////////////////////////////

  // Lowest unsent bit of the head entry goes out first
  assign pending = empty ? '0 : (vec_mem[rd_ptr_q] & ~sent_q);
  assign pick    = pending & (~pending + 1'b1);

  assign viol_valid_o = !empty && (credit_q != '0);
  assign viol_stamp_o = stamp_mem[rd_ptr_q];
  // Entry leaves once its last set bit is sent
  assign pop          = viol_valid_o && (pending == pick);

  always_comb begin
    viol_code_o = ctrl_monitor_pkg::CHK_B2B_BRANCH;
    for (int i = ctrl_monitor_pkg::N_CHECKS - 1; i >= 0; i--) begin
      if (pending[i]) begin
        viol_code_o = ctrl_monitor_pkg::check_e'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sent_q     <= '0;
      credit_q   <= CRD_W'(CREDITS);
      overflow_o <= 1'b0;
    end else begin
      if (viol_valid_o) begin
        sent_q <= pop ? '0 : (sent_q | pick);
      end
      credit_q <= credit_q - CRD_W'(viol_valid_o) + CRD_W'(credit_i);
      // Sticky until reset
      if ((flags_i != '0) && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // The consumer never returns more credits than it has been given
  a_credit_max :
    assert property (@(posedge clk) disable iff (!rst_n) credit_q <= CRD_W'(CREDITS))
      else $error("Credit count above the initial allocation");

endmodule

`default_nettype wire

// ==== rtl/ctrl_monitor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_monitor_top #(
  parameter int unsigned DEPTH   = 4,
  parameter int unsigned CREDITS = 2,
  parameter int unsigned STAMP_W = ctrl_monitor_pkg::STAMP_W_DEFAULT
) (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            pc_set_i,
  input  wire ctrl_monitor_pkg::pc_mux_e pc_mux_i,
  input  wire                            obi_req_i,
  input  wire                            obi_gnt_i,
  input  wire                            obi_we_i,
  input  wire                            obi_rvalid_i,
  input  wire                            obi_err_i,
  input  wire                            wb_valid_i,
  input  wire                            last_op_wb_i,
  input  wire                            fencei_in_wb_i,
  input  wire                            fencei_flush_req_i,
  input  wire                            fencei_flush_ack_i,
  input  wire                            fencei_ready_i,
  input  wire                            nmi_pending_i,
  input  wire                            nmi_is_store_i,
  input  wire                            credit_i,
  output logic                           viol_valid_o,
  output ctrl_monitor_pkg::check_e       viol_code_o,
  output logic [STAMP_W-1:0]             viol_stamp_o,
  output logic                           overflow_o
);

  ctrl_monitor_pkg::flow_flags_t flow_flags;
  ctrl_monitor_pkg::bus_flags_t  bus_flags;
  ctrl_monitor_pkg::chk_vec_t    chk_vec;

  ctrl_event_if #(.STAMP_W(STAMP_W)) ev ();

  ctrl_event_sampler #(.STAMP_W(STAMP_W)) u_sampler (
    .clk                (clk),
    .rst_n              (rst_n),
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .obi_req_i          (obi_req_i),
    .obi_gnt_i          (obi_gnt_i),
    .obi_we_i           (obi_we_i),
    .obi_rvalid_i       (obi_rvalid_i),
    .obi_err_i          (obi_err_i),
    .wb_valid_i         (wb_valid_i),
    .last_op_wb_i       (last_op_wb_i),
    .fencei_in_wb_i     (fencei_in_wb_i),
    .fencei_flush_req_i (fencei_flush_req_i),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .fencei_ready_i     (fencei_ready_i),
    .nmi_pending_i      (nmi_pending_i),
    .nmi_is_store_i     (nmi_is_store_i),
    .ev                 (ev.sampler)
  );

  bus_error_tracker u_bus_tracker (
    .clk     (clk),
    .rst_n   (rst_n),
    .ev      (ev.check),
    .flags_o (bus_flags)
  );

  ctrl_flow_checker u_flow_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .ev      (ev.check),
    .flags_o (flow_flags)
  );

  // Bus codes sit above the flow codes in the check vector
  assign chk_vec = {bus_flags, flow_flags};

  viol_reporter #(
    .DEPTH   (DEPTH),
    .CREDITS (CREDITS),
    .STAMP_W (STAMP_W)
  ) u_reporter (
    .clk          (clk),
    .rst_n        (rst_n),
    .ev           (ev.check),
    .flags_i      (chk_vec),
    .credit_i     (credit_i),
    .viol_valid_o (viol_valid_o),
    .viol_code_o  (viol_code_o),
    .viol_stamp_o (viol_stamp_o),
    .overflow_o   (overflow_o)
  );

endmodule

`default_nettype wire

// ==== tb/ctrl_monitor_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_monitor_tb;

  localparam int unsigned DEPTH         = 4;
  localparam int unsigned CREDITS       = 2;
  localparam int unsigned STAMP_W       = 16;
  localparam int          N_COLS        = 18;
  localparam int          DRAIN_TIMEOUT = 200;

  logic                      clk;
  logic                      rst_n;
  logic                      pc_set;
  ctrl_monitor_pkg::pc_mux_e pc_mux;
  logic                      obi_req;
  logic                      obi_gnt;
  logic                      obi_we;
  logic                      obi_rvalid;
  logic                      obi_err;
  logic                      wb_valid;
  logic                      last_op_wb;
  logic                      fencei_in_wb;
  logic                      fencei_flush_req;
  logic                      fencei_flush_ack;
  logic                      fencei_ready;
  logic                      nmi_pending;
  logic                      nmi_is_store;
  logic                      credit;
  logic                      viol_valid;
  ctrl_monitor_pkg::check_e  viol_code;
  logic [STAMP_W-1:0]        viol_stamp;
  logic                      overflow;

  // Expected records in the order they must leave the DUT
  logic [2:0]                exp_code_q [$];
  logic [STAMP_W-1:0]        exp_stamp_q [$];
  // Counts rising edges since reset release just as the DUT stamp does
  logic [STAMP_W-1:0]        edge_cnt;
  // Credits the DUT holds as seen from the consumer side
  int                        held_credits;
  logic                      exp_overflow;
  int                        fd;
  int                        n_fields;
  int                        wait_cnt;
  int                        col [N_COLS];
  string                     line;

  ctrl_monitor_top #(
    .DEPTH   (DEPTH),
    .CREDITS (CREDITS),
    .STAMP_W (STAMP_W)
  ) uut (
    .clk                (clk),
    .rst_n              (rst_n),
    .pc_set_i           (pc_set),
    .pc_mux_i           (pc_mux),
    .obi_req_i          (obi_req),
    .obi_gnt_i          (obi_gnt),
    .obi_we_i           (obi_we),
    .obi_rvalid_i       (obi_rvalid),
    .obi_err_i          (obi_err),
    .wb_valid_i         (wb_valid),
    .last_op_wb_i       (last_op_wb),
    .fencei_in_wb_i     (fencei_in_wb),
    .fencei_flush_req_i (fencei_flush_req),
    .fencei_flush_ack_i (fencei_flush_ack),
    .fencei_ready_i     (fencei_ready),
    .nmi_pending_i      (nmi_pending),
    .nmi_is_store_i     (nmi_is_store),
    .credit_i           (credit),
    .viol_valid_o       (viol_valid),
    .viol_code_o        (viol_code),
    .viol_stamp_o       (viol_stamp),
    .overflow_o         (overflow)
  );

  // 40 ns clock period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edge_cnt <= '0;
    end else begin
      edge_cnt <= edge_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helper tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  // All monitored inputs back to a quiet bus and controller
  task automatic drive_idle();
    pc_set           = 1'b0;
    pc_mux           = ctrl_monitor_pkg::PC_BOOT;
    obi_req          = 1'b0;
    obi_gnt          = 1'b0;
    obi_we           = 1'b0;
    obi_rvalid       = 1'b0;
    obi_err          = 1'b0;
    wb_valid         = 1'b0;
    last_op_wb       = 1'b0;
    fencei_in_wb     = 1'b0;
    fencei_flush_req = 1'b0;
    fencei_flush_ack = 1'b0;
    fencei_ready     = 1'b1;
    nmi_pending      = 1'b0;
    nmi_is_store     = 1'b0;
  endtask

  // One credit per cycle at most, and never more than the records taken
  task automatic return_credit(input logic enable);
    if (enable && (held_credits < CREDITS)) begin
      credit = 1'b1;
      held_credits++;
    end else begin
      credit = 1'b0;
    end
  endtask

  // Drives one vector line and queues the records it must produce
  task automatic apply_vector();
    logic [7:0] exp_vec;
    exp_vec          = col[16][7:0];
    pc_set           = col[0][0];
    pc_mux           = ctrl_monitor_pkg::pc_mux_e'(col[1][2:0]);
    obi_req          = col[2][0];
    obi_gnt          = col[3][0];
    obi_we           = col[4][0];
    obi_rvalid       = col[5][0];
    obi_err          = col[6][0];
    wb_valid         = col[7][0];
    last_op_wb       = col[8][0];
    fencei_in_wb     = col[9][0];
    fencei_flush_req = col[10][0];
    fencei_flush_ack = col[11][0];
    fencei_ready     = col[12][0];
    nmi_pending      = col[13][0];
    nmi_is_store     = col[14][0];
    // A vector that finds the FIFO full never becomes a record
    if (col[17] != 0) begin
      exp_overflow = 1'b1;
    end else begin
      // Sampled at the coming edge, so its stamp is one above the count
      for (int c = 0; c < 8; c++) begin
        if (exp_vec[c]) begin
          exp_code_q.push_back(3'(c));
          exp_stamp_q.push_back(edge_cnt + 1'b1);
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Record monitor
  //////////////////////////////////////////////////////////////////////

  // Outputs come from registers only, so the values before the edge are the sent record
  always @(posedge clk) begin
    if (rst_n && viol_valid) begin
      if (exp_code_q.size() == 0) begin
        $display("Error at %0t ns: a violation record arrived that no vector predicts", $time);
        abort_run();
      end else if (held_credits - int'(credit) <= 0) begin
        // The credit driven in this cycle only reaches the DUT at this edge
        $display("Error at %0t ns: a record was sent while the DUT held no credit", $time);
        abort_run();
      end else begin
        held_credits--;
        check_value("viol_code_o", 32'(viol_code), 32'(exp_code_q.pop_front()));
        check_value("viol_stamp_o", 32'(viol_stamp), 32'(exp_stamp_q.pop_front()));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus from the vector file
  //////////////////////////////////////////////////////////////////////

  initial begin
    drive_idle();
    credit       = 1'b0;
    rst_n        = 1'b0;
    held_credits = CREDITS;
    exp_overflow = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen("tb/ctrl_monitor_vectors.txt", "r");
    if (fd == 0) begin
      $display("Error: the vector file tb/ctrl_monitor_vectors.txt cannot be opened");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      // Comment and empty lines hold no vector
      if ((line.len() < 2) || (line.substr(0, 1) == "//")) begin
        continue;
      end
      n_fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %h %d",
                         col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                         col[7], col[8], col[9], col[10], col[11], col[12],
                         col[13], col[14], col[15], col[16], col[17]);
      if (n_fields != N_COLS) begin
        $display("Error: vector line has %0d fields instead of %0d: %s",
                 n_fields, N_COLS, line);
        abort_run();
      end
      @(negedge clk);
      apply_vector();
      return_credit(col[15] != 0);
    end
    $fclose(fd);

    // Hand back credits until every expected record has left
    wait_cnt = 0;
    while (exp_code_q.size() != 0) begin
      @(negedge clk);
      drive_idle();
      return_credit(1'b1);
      wait_cnt++;
      if (wait_cnt > DRAIN_TIMEOUT) begin
        $display("Error: %0d expected violation records never came out of the DUT",
                 exp_code_q.size());
        abort_run();
      end
    end

    // A few quiet cycles let any surplus record reach the monitor
    repeat (4) begin
      @(negedge clk);
      drive_idle();
      return_credit(1'b1);
    end
    check_value("overflow_o", 32'(overflow), 32'(exp_overflow));
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ctrl_monitor.f ====
rtl/ctrl_monitor_pkg.sv
rtl/ctrl_event_if.sv
rtl/ctrl_event_sampler.sv
rtl/bus_error_tracker.sv
rtl/ctrl_flow_checker.sv
rtl/viol_reporter.sv
rtl/ctrl_monitor_top.sv
tb/ctrl_monitor_tb.sv

// ==== Bender.yml ====
package:
  name: ctrl_monitor

sources:
  # Package first, then the interface and the modules below the top level
  - rtl/ctrl_monitor_pkg.sv
  - rtl/ctrl_event_if.sv
  - rtl/ctrl_event_sampler.sv
  - rtl/bus_error_tracker.sv
  - rtl/ctrl_flow_checker.sv
  - rtl/viol_reporter.sv
  - rtl/ctrl_monitor_top.sv

  - target: test
    files:
      - tb/ctrl_monitor_tb.sv

// ==== tb/ctrl_monitor_vectors.txt ====
// set mux | req gnt we rvalid err | wb last | in_wb freq fack frdy | npend nstore | credit_en
// then the expected check vector in hex and drop (1 = vector finds the FIFO full)
// Back-to-back redirects
1 3  0 0 0 0 0  0 0  0 0 0 1  0 0  1  00 0
1 3  0 0 0 0 0  0 0  0 0 0 1  0 0  1  01 0
0 0  0 0 0 0 0  0 0  0 0 0 1  0 0  1  00 0
1 3  0 0 0 0 0  0 0  0 0 0 1  0 0  1  00 0
1 1  0 0 0 0 0  0 0  0 0 0 1  0 0  1  00 0
1 2  0 0 0 0 0  0 0  0 0 0 1  0 0  1  02 0
// Fence.i flush handshake
0 0  0 0 0 0 0  0 0  1 1 0 1  0 0  1  00 0
0 0  0 0 0 0 0  0 0  1 1 1 1  0 0  1  00 0
0 0  0 0 0 0 0  0 0  0 0 0 1  0 0  1  00 0
0 0  0 0 0 0 0  0 0  0 1 1 1  0 0  1  04 0
0 0  0 0 0 0 0  0 0  0 0 0 1  0 0  1  00 0
0 0  0 0 0 0 0  0 0  1 1 0 0  0 0  1  20 0
0 0  0 0 0 0 0  0 0  0 0 0 1  0 0  1  08 0
0 0  0 0 0 0 0  0 0  1 1 1 1  0 0  1  00 0
0 0  0 0 0 0 0  0 0  0 1 0 0  0 0  1  34 0
0 0  0 0 0 0 0  0 0  0 0 0 1  0 0  1  08 0
// Bus error with correct NMI type, then wrong type and retire limits
0 0  1 1 1 0 0  0 0  0 0 0 1  0 0  1  00 0
0 0  1 1 0 0 0  0 0  0 0 0 1  0 0  1  00 0
0 0  0 0 0 1 1  0 0  0 0 0 1  0 0  1  00 0
1 4  0 0 0 0 0  0 0  0 0 0 1  1 1  1  00 0
0 0  1 1 1 1 0  0 0  0 0 0 1  0 0  1  00 0
0 0  1 1 0 0 0  0 0  0 0 0 1  0 0  1  00 0
0 0  0 0 0 1 1  0 0  0 0 0 1  0 0  1  00 0
0 0  0 0 0 1 0  1 1  0 0 0 1  1 0  1  40 0
0 0  0 0 0 0 0  1 1  0 0 0 1  0 0  1  00 0
0 0  0 0 0 0 0  1 1  0 0 0 1  0 0  1  80 0
1 4  0 0 0 0 0  1 1  0 0 0 1  0 0  1  00 0
0 0  1 1 0 0 0  0 0  0 0 0 1  0 0  1  00 0
0 0  0 0 0 1 1  1 1  0 0 0 1  0 0  1  00 0
0 0  0 0 0 0 0  1 1  0 0 0 1  1 0  1  00 0
0 0  0 0 0 0 0  1 1  0 0 0 1  0 0  1  80 0
1 4  0 0 0 0 0  0 0  0 0 0 1  0 0  1  00 0
0 0  0 0 0 0 0  0 0  0 0 0 1  0 0  1  00 0
0 0  0 0 0 0 0  0 0  0 0 0 1  0 0  1  00 0
// No credits returned while branches repeat, the last one overflows
1 3  0 0 0 0 0  0 0  0 0 0 1  0 0  0  00 0
1 3  0 0 0 0 0  0 0  0 0 0 1  0 0  0  01 0
1 3  0 0 0 0 0  0 0  0 0 0 1  0 0  0  01 0
1 3  0 0 0 0 0  0 0  0 0 0 1  0 0  0  01 0
1 3  0 0 0 0 0  0 0  0 0 0 1  0 0  0  01 0
1 3  0 0 0 0 0  0 0  0 0 0 1  0 0  0  01 0
1 3  0 0 0 0 0  0 0  0 0 0 1  0 0  0  01 0
1 3  0 0 0 0 0  0 0  0 0 0 1  0 0  0  01 1
0 0  0 0 0 0 0  0 0  0 0 0 1  0 0  0  00 0
0 0  0 0 0 0 0  0 0  0 0 0 1  0 0  1  00 0
0 0  0 0 0 0 0  0 0  0 0 0 1  0 0  1  00 0
